//--- verilog/cpuPkg.sv
package cpuPkg;

    //////////////////////////////
    // Widths fixed by the instruction format
    //////////////////////////////

    // Opcode 15:13, rd 12:11, rs 10:9, spare bit 8, imm 7:0
    typedef logic [15:0] inst_t;
    typedef logic [7:0]  data_t;
    typedef logic [1:0]  regAddr_t;

    // Flag pair seen by the decoder
    typedef logic [1:0]  cond_t;

    localparam int CondCarry = 1;
    localparam int CondZero  = 0;

    localparam int NumRegs = 4;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    typedef enum logic [2:0] {
        OpNop  = 3'b000,
        OpAddi = 3'b001,
        OpAdd  = 3'b010,
        OpSubi = 3'b011,
        OpAndi = 3'b100,
        OpOri  = 3'b101,
        OpLdi  = 3'b110,
        OpSkip = 3'b111
    } opcode_t;

    typedef enum logic [2:0] {
        AluPass = 3'b000,
        AluAdd  = 3'b001,
        AluSub  = 3'b010,
        AluAnd  = 3'b011,
        AluOr   = 3'b100
    } aluFunc_t;

    // What an instruction does once done is high
    typedef enum logic [1:0] {
        ActWrite = 2'b00,
        ActLoad  = 2'b01,
        ActSkip1 = 2'b10,
        ActSkip2 = 2'b11
    } action_t;

    typedef enum logic {
        SeqRun  = 1'b0,
        SeqSkip = 1'b1
    } seqState_t;

endpackage

//--- verilog/control.sv
`timescale 1ns/1ps

module control (
    input  cpuPkg::opcode_t  opcode,
    input  cpuPkg::cond_t    cond,
    output logic             selR,
    output cpuPkg::aluFunc_t aluFunc,
    output logic             done,
    output cpuPkg::action_t  action
);
    import cpuPkg::*;

    logic skipOne;
    logic skipTwo;

    // Skip conditions taken from the flag pair
    assign skipOne = cond[CondZero] && !cond[CondCarry];
    assign skipTwo = cond[CondZero] && cond[CondCarry];

    always_comb
    begin
        // Defaults describe a no-op
        selR    = 1'b0;
        aluFunc = AluPass;
        done    = 1'b0;
        action  = ActWrite;

        case (opcode)
            OpAddi:
            begin
                aluFunc = AluAdd;
                done    = 1'b1;
            end
            OpAdd:
            begin
                // Only opcode with a register operand
                selR    = 1'b1;
                aluFunc = AluAdd;
                done    = 1'b1;
            end
            OpSubi:
            begin
                aluFunc = AluSub;
                done    = 1'b1;
            end
            OpAndi:
            begin
                aluFunc = AluAnd;
                done    = 1'b1;
            end
            OpOri:
            begin
                aluFunc = AluOr;
                done    = 1'b1;
            end
            OpLdi:
            begin
                done   = 1'b1;
                action = ActLoad;
            end
            OpSkip:
            begin
                if (skipOne)
                begin
                    done   = 1'b1;
                    action = ActSkip1;
                end
                else if (skipTwo)
                begin
                    done   = 1'b1;
                    action = ActSkip2;
                end
            end
            default:
            begin
                // OpNop takes no action
                done = 1'b0;
            end
        endcase
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Loads and skips never carry an ALU operation
    always_comb
    begin
        assert (!(done && action != ActWrite && aluFunc != AluPass))
            else $error("control: ALU function on a non-write action");
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpuPkg::data_t    opA,
    input  cpuPkg::data_t    regB,
    input  cpuPkg::data_t    imm,
    input  logic             selR,
    input  cpuPkg::aluFunc_t func,
    output cpuPkg::data_t    result,
    output logic             carry,
    output logic             zero
);
    import cpuPkg::*;

    data_t       opB;
    logic [8:0]  sum;
    logic [8:0]  diff;

    // Operand B from rs or the immediate
    assign opB = selR ? regB : imm;

    // Ninth bit holds carry out or borrow
    assign sum  = {1'b0, opA} + {1'b0, opB};
    assign diff = {1'b0, opA} - {1'b0, opB};

    always_comb
    begin
        result = opB;
        carry  = 1'b0;

        case (func)
            AluPass:
            begin
                result = opB;
            end
            AluAdd:
            begin
                result = sum[7:0];
                carry  = sum[8];
            end
            AluSub:
            begin
                // Borrow reported as carry
                result = diff[7:0];
                carry  = diff[8];
            end
            AluAnd:
            begin
                result = opA & opB;
            end
            AluOr:
            begin
                result = opA | opB;
            end
            default:
            begin
                result = opB;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  cpuPkg::regAddr_t rdAddrA,
    input  cpuPkg::regAddr_t rdAddrB,
    output cpuPkg::data_t    rdDataA,
    output cpuPkg::data_t    rdDataB,
    input  logic             wrEn,
    input  cpuPkg::regAddr_t wrAddr,
    input  cpuPkg::data_t    wrData
);
    import cpuPkg::*;

    data_t regs [NumRegs];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NumRegs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrEn)
        begin
            regs[wrAddr] <= wrData;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////

    // Asynchronous, so a write shows up on the next cycle
    assign rdDataA = regs[rdAddrA];
    assign rdDataB = regs[rdAddrB];

endmodule

//--- verilog/sequencer.sv
`timescale 1ns/1ps

module sequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             instValid,
    output logic             instReady,
    input  logic             done,
    input  cpuPkg::action_t  action,
    input  cpuPkg::regAddr_t rd,
    input  cpuPkg::data_t    imm,
    input  cpuPkg::data_t    aluResult,
    input  logic             aluCarry,
    input  logic             aluZero,
    output cpuPkg::cond_t    flags,
    output logic             wrEn,
    output cpuPkg::regAddr_t wrAddr,
    output cpuPkg::data_t    wrData,
    output logic             resValid,
    input  logic             resReady,
    output cpuPkg::regAddr_t resReg,
    output cpuPkg::data_t    resData
);
    import cpuPkg::*;

    seqState_t  state;
    logic [1:0] skipCnt;
    logic       carryQ;
    logic       zeroQ;
    logic       accept;
    logic       runAccept;
    logic       isLoad;
    logic       isSkip;

    // Stall only while a result is stuck at the sink
    assign instReady = !resValid || resReady;
    assign accept    = instValid && instReady;
    assign runAccept = accept && (state == SeqRun);

    assign isLoad = (action == ActLoad);
    assign isSkip = done && (action == ActSkip1 || action == ActSkip2);

    assign wrEn   = runAccept && done && (action == ActWrite || isLoad);
    assign wrAddr = rd;
    assign wrData = isLoad ? imm : aluResult;

    assign flags[CondCarry] = carryQ;
    assign flags[CondZero]  = zeroQ;

    //////////////////////////////
    // Skip FSM
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= SeqRun;
            skipCnt <= 2'd0;
        end
        else if (accept)
        begin
            case (state)
                SeqRun:
                begin
                    if (isSkip)
                    begin
                        state   <= SeqSkip;
                        skipCnt <= (action == ActSkip2) ? 2'd2 : 2'd1;
                    end
                end
                default:
                begin
                    // Accepted but thrown away
                    skipCnt <= skipCnt - 2'd1;
                    if (skipCnt == 2'd1)
                    begin
                        state <= SeqRun;
                    end
                end
            endcase
        end
    end

    //////////////////////////////
    // Flags and result stream
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            carryQ   <= 1'b0;
            zeroQ    <= 1'b0;
            resValid <= 1'b0;
        end
        else
        begin
            if (wrEn)
            begin
                // A load clears carry and tests the immediate
                carryQ <= isLoad ? 1'b0 : aluCarry;
                zeroQ  <= isLoad ? (imm == '0) : aluZero;
            end
            if (wrEn)
            begin
                resValid <= 1'b1;
            end
            else if (resReady)
            begin
                resValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (wrEn)
        begin
            resReg  <= rd;
            resData <= wrData;
        end
    end

    // Held result must not move until the sink takes it
    assert property (@(posedge clk) disable iff (rst)
        resValid && !resReady |=> resValid && $stable(resReg) && $stable(resData))
        else $error("sequencer: result changed under back-pressure");

    // Writes only come from instructions accepted outside a skip
    assert property (@(posedge clk) disable iff (rst)
        wrEn |-> instValid && instReady && state == SeqRun)
        else $error("sequencer: register write without an accepted instruction");

endmodule

//--- verilog/microTop.sv
`timescale 1ns/1ps

module microTop (
    input  logic             clk,
    input  logic             rst,
    input  logic             instValid,
    input  cpuPkg::inst_t    inst,
    output logic             instReady,
    output logic             resValid,
    input  logic             resReady,
    output cpuPkg::regAddr_t resReg,
    output cpuPkg::data_t    resData
);
    import cpuPkg::*;

    opcode_t  opcode;
    regAddr_t rd;
    regAddr_t rs;
    data_t    imm;

    cond_t    flags;
    logic     selR;
    aluFunc_t aluFunc;
    logic     done;
    action_t  action;

    data_t    regA;
    data_t    regB;
    data_t    aluResult;
    logic     aluCarry;
    logic     aluZero;

    logic     wrEn;
    regAddr_t wrAddr;
    data_t    wrData;

    // Instruction fields, bit 8 is spare
    assign opcode = opcode_t'(inst[15:13]);
    assign rd     = inst[12:11];
    assign rs     = inst[10:9];
    assign imm    = inst[7:0];

    control ctrl (
        .opcode  (opcode),
        .cond    (flags),
        .selR    (selR),
        .aluFunc (aluFunc),
        .done    (done),
        .action  (action)
    );

    // rd is always operand A
    alu aluUnit (
        .opA    (regA),
        .regB   (regB),
        .imm    (imm),
        .selR   (selR),
        .func   (aluFunc),
        .result (aluResult),
        .carry  (aluCarry),
        .zero   (aluZero)
    );

    regFile regs (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rd),
        .rdAddrB (rs),
        .rdDataA (regA),
        .rdDataB (regB),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    sequencer seqUnit (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .instReady (instReady),
        .done      (done),
        .action    (action),
        .rd        (rd),
        .imm       (imm),
        .aluResult (aluResult),
        .aluCarry  (aluCarry),
        .aluZero   (aluZero),
        .flags     (flags),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .resValid  (resValid),
        .resReady  (resReady),
        .resReg    (resReg),
        .resData   (resData)
    );

endmodule

//--- dv/microTb.sv
`timescale 1ns/1ps

module microTb;
    import cpuPkg::*;

    localparam int Timeout    = 50;
    localparam int NumRandom  = 200;
    localparam int MaxToggles = 20000;

    logic     clk;
    logic     rst;
    logic     instValid;
    inst_t    inst;
    logic     instReady;
    logic     resValid;
    logic     resReady;
    regAddr_t resReg;
    data_t    resData;

    // Software model of the core
    data_t       modelRegs [4];
    logic        modelCarry;
    logic        modelZero;
    int          modelSkip;
    logic [9:0]  expQ [$];

    int          errors;
    int          timeouts;
    integer      seed;
    logic        randomActive;
    inst_t       stream [NumRandom];
    logic        readyBits [256];

    microTop UUT (
        .clk       (clk),
        .rst       (rst),
        .instValid (instValid),
        .inst      (inst),
        .instReady (instReady),
        .resValid  (resValid),
        .resReady  (resReady),
        .resReg    (resReg),
        .resData   (resData)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Model and helpers
    //////////////////////////////

    function automatic inst_t encode(input opcode_t op, input regAddr_t rd,
                                     input regAddr_t rs, input data_t imm);
        return {op, rd, rs, 1'b0, imm};
    endfunction

    // One accepted instruction, straight from the instruction rules
    function automatic void modelStep(input inst_t word);
        opcode_t    op;
        regAddr_t   rdF;
        regAddr_t   rsF;
        data_t      immF;
        logic [8:0] wide;
        logic       writes;
        op     = opcode_t'(word[15:13]);
        rdF    = word[12:11];
        rsF    = word[10:9];
        immF   = word[7:0];
        wide   = '0;
        writes = 1'b0;
        if (modelSkip > 0)
        begin
            modelSkip--;
        end
        else
        begin
            writes = 1'b1;
            case (op)
                OpAddi: wide = {1'b0, modelRegs[rdF]} + {1'b0, immF};
                OpAdd:  wide = {1'b0, modelRegs[rdF]} + {1'b0, modelRegs[rsF]};
                OpSubi: wide = {1'b0, modelRegs[rdF]} - {1'b0, immF};
                OpAndi: wide = {1'b0, modelRegs[rdF] & immF};
                OpOri:  wide = {1'b0, modelRegs[rdF] | immF};
                OpLdi:  wide = {1'b0, immF};
                OpSkip:
                begin
                    writes = 1'b0;
                    if (modelZero && !modelCarry)
                        modelSkip = 1;
                    else if (modelZero && modelCarry)
                        modelSkip = 2;
                end
                default: writes = 1'b0;
            endcase
        end
        if (writes)
        begin
            modelRegs[rdF] = wide[7:0];
            modelCarry     = wide[8];
            modelZero      = (wide[7:0] == 8'd0);
            expQ.push_back({rdF, wide[7:0]});
        end
    endfunction

    task automatic sendInst(input inst_t word);
        int n;
        n         = 0;
        instValid = 1'b1;
        inst      = word;
        @(posedge clk);
        while (!instReady && n < Timeout)
        begin
            @(posedge clk);
            n++;
        end
        if (!instReady)
        begin
            timeouts++;
            $display("Timeout: instruction %h was never accepted", word);
        end
        else
        begin
            modelStep(word);
        end
        #1;
        instValid = 1'b0;
        inst      = '0;
    endtask

    // Compare one transferred result with the oldest expected one
    task automatic expectResult;
        logic [9:0] exp;
        assert (expQ.size() > 0)
            else
            begin
                errors++;
                $display("Result r%0d=%h arrived with none expected at %0t",
                         resReg, resData, $time);
            end
        if (expQ.size() > 0)
        begin
            exp = expQ.pop_front();
            assert (resReg == exp[9:8] && resData == exp[7:0])
                else
                begin
                    errors++;
                    $display("FAILED at %0t: got r%0d=%h, expected r%0d=%h",
                             $time, resReg, resData, exp[9:8], exp[7:0]);
                end
        end
    endtask

    always @(posedge clk)
    begin
        if (!rst && resValid && resReady)
            expectResult();
    end

    task automatic drainResults;
        int n;
        n = 0;
        while (expQ.size() != 0 && n < Timeout)
        begin
            @(posedge clk);
            n++;
        end
        if (expQ.size() != 0)
        begin
            timeouts++;
            $display("Timeout: %0d expected results never arrived", expQ.size());
            expQ.delete();
        end
        // Quiet window so stray results get caught
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic toggleReady;
        int cyc;
        cyc = 0;
        while (randomActive && cyc < MaxToggles)
        begin
            @(posedge clk);
            #1;
            resReady = readyBits[cyc % 256];
            cyc++;
        end
    endtask

    task automatic finishRun;
        $display("Summary: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic driveLoadsImm;
        for (int r = 0; r < 4; r++)
        begin
            sendInst(encode(OpLdi, regAddr_t'(r), 2'd0, data_t'(r * 37 + 5)));
        end
        sendInst(encode(OpAddi, 2'd0, 2'd0, 8'h25));
        sendInst(encode(OpSubi, 2'd1, 2'd0, 8'h05));
        sendInst(encode(OpAndi, 2'd2, 2'd0, 8'h0f));
        sendInst(encode(OpOri,  2'd3, 2'd0, 8'ha0));
        // Wrap in both directions
        sendInst(encode(OpSubi, 2'd0, 2'd0, 8'hf0));
        sendInst(encode(OpAddi, 2'd3, 2'd0, 8'hc0));
        drainResults();
    endtask

    task automatic addRegisters;
        sendInst(encode(OpAdd, 2'd0, 2'd1, 8'h00));
        sendInst(encode(OpAdd, 2'd2, 2'd2, 8'h00));
        sendInst(encode(OpAdd, 2'd3, 2'd0, 8'h00));
        sendInst(encode(OpAdd, 2'd1, 2'd1, 8'h00));
        drainResults();
    endtask

    task automatic exerciseSkips;
        // Zero without carry
        sendInst(encode(OpLdi,  2'd0, 2'd0, 8'h00));
        sendInst(encode(OpSkip, 2'd0, 2'd0, 8'h00));
        sendInst(encode(OpLdi,  2'd1, 2'd0, 8'h55));
        sendInst(encode(OpAddi, 2'd1, 2'd0, 8'h00));
        // 255 plus 1 sets both flags
        sendInst(encode(OpLdi,  2'd2, 2'd0, 8'hff));
        sendInst(encode(OpAddi, 2'd2, 2'd0, 8'h01));
        sendInst(encode(OpSkip, 2'd0, 2'd0, 8'h00));
        sendInst(encode(OpLdi,  2'd0, 2'd0, 8'h11));
        sendInst(encode(OpAddi, 2'd3, 2'd0, 8'h22));
        sendInst(encode(OpAddi, 2'd0, 2'd0, 8'h00));
        sendInst(encode(OpAddi, 2'd3, 2'd0, 8'h00));
        // Carry alone, then no flags
        sendInst(encode(OpLdi,  2'd2, 2'd0, 8'hf0));
        sendInst(encode(OpAddi, 2'd2, 2'd0, 8'h20));
        sendInst(encode(OpSkip, 2'd0, 2'd0, 8'h00));
        sendInst(encode(OpAddi, 2'd2, 2'd0, 8'h00));
        sendInst(encode(OpSkip, 2'd0, 2'd0, 8'h00));
        sendInst(encode(OpAddi, 2'd1, 2'd0, 8'h01));
        // A skip that is itself skipped
        sendInst(encode(OpLdi,  2'd0, 2'd0, 8'h00));
        sendInst(encode(OpSkip, 2'd0, 2'd0, 8'h00));
        sendInst(encode(OpSkip, 2'd0, 2'd0, 8'h00));
        sendInst(encode(OpAddi, 2'd0, 2'd0, 8'h01));
        drainResults();
    endtask

    task automatic checkNops;
        sendInst(encode(OpLdi,  2'd2, 2'd0, 8'h03));
        sendInst(encode(OpSubi, 2'd2, 2'd0, 8'h03));
        sendInst(encode(OpNop,  2'd2, 2'd1, 8'hff));
        sendInst(encode(OpNop,  2'd0, 2'd0, 8'h00));
        // Flags still say zero
        sendInst(encode(OpSkip, 2'd0, 2'd0, 8'h00));
        sendInst(encode(OpLdi,  2'd1, 2'd0, 8'h77));
        sendInst(encode(OpAddi, 2'd1, 2'd0, 8'h00));
        sendInst(encode(OpLdi,  2'd3, 2'd0, 8'hff));
        sendInst(encode(OpAddi, 2'd3, 2'd0, 8'h02));
        sendInst(encode(OpSkip, 2'd0, 2'd0, 8'h00));
        // Second skip sees the same carry-only flags
        sendInst(encode(OpSkip, 2'd0, 2'd0, 8'h00));
        sendInst(encode(OpAddi, 2'd3, 2'd0, 8'h00));
        drainResults();
    endtask

    task automatic holdResult;
        resReady = 1'b0;
        sendInst(encode(OpLdi, 2'd1, 2'd0, 8'h3c));
        instValid = 1'b1;
        inst      = encode(OpAddi, 2'd1, 2'd0, 8'h01);
        repeat (5)
        begin
            @(posedge clk);
            assert (!instReady && resValid && expQ.size() == 1
                    && resReg == expQ[0][9:8] && resData == expQ[0][7:0])
                else
                begin
                    errors++;
                    $display("FAILED at %0t: held result or instReady wrong", $time);
                end
        end
        #1;
        resReady = 1'b1;
        sendInst(encode(OpAddi, 2'd1, 2'd0, 8'h01));
        sendInst(encode(OpAdd,  2'd2, 2'd1, 8'h00));
        drainResults();
    endtask

    task automatic streamRandom;
        logic [31:0] rnd;
        seed = 5591;
        for (int i = 0; i < NumRandom; i++)
        begin
            rnd       = $random(seed);
            stream[i] = rnd[15:0];
        end
        for (int i = 0; i < 256; i++)
        begin
            rnd          = $random(seed);
            readyBits[i] = (rnd[1:0] != 2'b00);
        end
        randomActive = 1'b1;
        fork
            begin
                for (int i = 0; i < NumRandom; i++)
                begin
                    sendInst(stream[i]);
                end
                randomActive = 1'b0;
            end
            toggleReady();
        join
        resReady = 1'b1;
        drainResults();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        errors       = 0;
        timeouts     = 0;
        seed         = 5591;
        randomActive = 1'b0;
        rst          = 1'b1;
        instValid    = 1'b0;
        inst         = '0;
        resReady     = 1'b1;
        modelCarry   = 1'b0;
        modelZero    = 1'b0;
        modelSkip    = 0;
        for (int r = 0; r < 4; r++)
        begin
            modelRegs[r] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (instReady && !resValid)
            else
            begin
                errors++;
                $display("FAILED at %0t: handshake state after reset", $time);
            end

        driveLoadsImm();
        addRegisters();
        exerciseSkips();
        checkNops();
        holdResult();
        streamRandom();
        finishRun();
    end

endmodule

//--- sim.f
verilog/cpuPkg.sv
verilog/control.sv
verilog/alu.sv
verilog/regFile.sv
verilog/sequencer.sv
verilog/microTop.sv
dv/microTb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module microTb -f sim.f -o microSim || exit 1
out=$(./obj_dir/microSim)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
